// ==== source/ent_ht_pkg.sv ====
/*
 * Entropy health-test shared definitions
 * Counter and symbol widths, adaptive proportion window and alert FSM states
 */

package ent_ht_pkg;

  // Counter and threshold width
  localparam int RegWidth = 16;

  // Noise symbol width
  localparam int RngBusWidth = 4;

  // Valid samples per adaptive proportion window
  localparam int ApWindow = 16;

  // Window sample index width, must cover ApWindow-1
  localparam int ApWinWidth = 4;

  // Alert controller states
  typedef enum logic [1:0] {
    // Test disabled or cleared
    AlIdle  = 2'd0,
    // Counting failures
    AlRun   = 2'd1,
    // Failure limit reached, alert level high
    AlAlert = 2'd2
  } alert_state_e;

endpackage : ent_ht_pkg

// ==== source/redun_count.sv ====
/*
 * Hardened counter with set and saturating increment
 * A complement copy runs in lockstep and any disagreement raises err_o
 */

`timescale 1ns/100ps

module redun_count (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            set_i,
  input  logic [ent_ht_pkg::RegWidth-1:0] set_cnt_i,
  input  logic                            incr_en_i,
  output logic [ent_ht_pkg::RegWidth-1:0] cnt_o,
  output logic                            err_o
);

  // Primary count
  logic [ent_ht_pkg::RegWidth-1:0] cnt_q, cnt_d;
  // Complement copy, ~cnt_q when healthy
  logic [ent_ht_pkg::RegWidth-1:0] cnt_inv_q, cnt_inv_d;

  // Primary path, set wins over increment
  always_comb begin
    cnt_d = cnt_q;
    if (set_i) begin
      cnt_d = set_cnt_i;
    end else if (incr_en_i && !(&cnt_q)) begin
      // Saturate at all ones
      cnt_d = cnt_q + 1'b1;
    end
  end

  // Complement path computed on its own
  // Increment of the count is a decrement here
  always_comb begin
    cnt_inv_d = cnt_inv_q;
    if (set_i) begin
      cnt_inv_d = ~set_cnt_i;
    end else if (incr_en_i && (|cnt_inv_q)) begin
      // All zeros here is saturation of the count
      cnt_inv_d = cnt_inv_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      cnt_inv_q <= '1;
    end else begin
      cnt_q     <= cnt_d;
      cnt_inv_q <= cnt_inv_d;
    end
  end

  assign cnt_o = cnt_q;

  // Copies disagree
  assign err_o = (cnt_q != ~cnt_inv_q);

endmodule : redun_count

// ==== source/repcnt_ht.sv ====
/*
 * Repetition count health test
 * Counts identical noise symbols in a row and pulses on reaching the threshold
 */

`timescale 1ns/100ps

module repcnt_ht (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [ent_ht_pkg::RngBusWidth-1:0] entropy_bit_i,
  input  logic                               entropy_bit_vld_i,
  input  logic                               clear_i,
  input  logic                               active_i,
  input  logic [ent_ht_pkg::RegWidth-1:0]    thresh_i,
  output logic [ent_ht_pkg::RegWidth-1:0]    test_cnt_o,
  output logic                               test_fail_pulse_o,
  output logic                               count_err_o
);

  logic                               restart;
  logic                               match_pulse;
  logic                               mismatch_pulse;
  logic [ent_ht_pkg::RegWidth-1:0]    rep_cnt;
  logic                               rep_cnt_err;
  logic [ent_ht_pkg::RngBusWidth-1:0] prev_sym_q, prev_sym_d;
  // Marks the cycle right after a counter update
  logic                               upd_mask_q;

  // Disabled or cleared
  assign restart = !active_i || clear_i;

  // Previous symbol, back to 0 on restart
  always_comb begin
    prev_sym_d = prev_sym_q;
    if (restart) begin
      prev_sym_d = '0;
    end else if (entropy_bit_vld_i) begin
      prev_sym_d = entropy_bit_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_sym_q <= '0;
      upd_mask_q <= 1'b0;
    end else begin
      prev_sym_q <= prev_sym_d;
      upd_mask_q <= entropy_bit_vld_i;
    end
  end

  // Compare each valid sample with the last one
  assign match_pulse    = entropy_bit_vld_i && (entropy_bit_i == prev_sym_q);
  assign mismatch_pulse = entropy_bit_vld_i && (entropy_bit_i != prev_sym_q);

  // Run length, starts at 1 like the first symbol of a run
  redun_count u_rep_cnt (
    .clk_i,
    .rst_ni,
    .set_i     (restart || mismatch_pulse),
    .set_cnt_i (ent_ht_pkg::RegWidth'(1)),
    .incr_en_i (match_pulse),
    .cnt_o     (rep_cnt),
    .err_o     (rep_cnt_err)
  );

  // Sample the comparison once per update
  assign test_fail_pulse_o = active_i && upd_mask_q && (rep_cnt >= thresh_i);

  assign test_cnt_o  = rep_cnt;
  assign count_err_o = rep_cnt_err;

endmodule : repcnt_ht

// ==== source/adaptp_ht.sv ====
/*
 * Adaptive proportion health test
 * Counts how often the first symbol of a fixed window recurs within it
 * and pulses at window end when the count reaches the threshold
 */

`timescale 1ns/100ps

module adaptp_ht (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [ent_ht_pkg::RngBusWidth-1:0] entropy_bit_i,
  input  logic                               entropy_bit_vld_i,
  input  logic                               clear_i,
  input  logic                               active_i,
  input  logic [ent_ht_pkg::RegWidth-1:0]    thresh_i,
  output logic [ent_ht_pkg::RegWidth-1:0]    test_cnt_o,
  output logic                               test_fail_pulse_o,
  output logic                               count_err_o
);

  localparam logic [ent_ht_pkg::ApWinWidth-1:0] LastIdx =
    ent_ht_pkg::ApWinWidth'(ent_ht_pkg::ApWindow - 1);

  logic                               restart;
  logic                               win_first;
  logic                               win_last;
  logic                               sym_match;
  logic [ent_ht_pkg::RegWidth-1:0]    ap_set_cnt;
  logic [ent_ht_pkg::RegWidth-1:0]    ap_cnt;
  logic                               ap_cnt_err;
  logic [ent_ht_pkg::ApWinWidth-1:0]  win_idx_q, win_idx_d;
  logic                               win_end_q, win_end_d;
  // Reference symbol of the current window
  logic [ent_ht_pkg::RngBusWidth-1:0] ref_sym_q;

  assign restart = !active_i || clear_i;

  // Position of this valid sample in the window
  assign win_first = entropy_bit_vld_i && (win_idx_q == '0);
  assign win_last  = entropy_bit_vld_i && (win_idx_q == LastIdx);

  // Later samples matching the reference
  assign sym_match = entropy_bit_vld_i && (win_idx_q != '0) &&
                     (entropy_bit_i == ref_sym_q);

  // Sample index, wraps after the last sample
  always_comb begin
    win_idx_d = win_idx_q;
    if (restart) begin
      win_idx_d = '0;
    end else if (win_last) begin
      win_idx_d = '0;
    end else if (entropy_bit_vld_i) begin
      win_idx_d = win_idx_q + 1'b1;
    end
  end

  // Window closes on this sample
  assign win_end_d = win_last && !restart;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      win_idx_q <= '0;
      win_end_q <= 1'b0;
    end else begin
      win_idx_q <= win_idx_d;
      win_end_q <= win_end_d;
    end
  end

  // First sample becomes the reference
  always_ff @(posedge clk_i) begin
    if (win_first) begin
      ref_sym_q <= entropy_bit_i;
    end
  end

  // Zero while idle, 1 on a window's first sample
  assign ap_set_cnt = restart ? '0 : ent_ht_pkg::RegWidth'(1);

  // Final count stays until the next window starts
  redun_count u_ap_cnt (
    .clk_i,
    .rst_ni,
    .set_i     (restart || win_first),
    .set_cnt_i (ap_set_cnt),
    .incr_en_i (sym_match),
    .cnt_o     (ap_cnt),
    .err_o     (ap_cnt_err)
  );

  // One compare per closed window
  assign test_fail_pulse_o = active_i && win_end_q && (ap_cnt >= thresh_i);

  assign test_cnt_o  = ap_cnt;
  assign count_err_o = ap_cnt_err;

endmodule : adaptp_ht

// ==== source/ht_watermark.sv ====
/*
 * Health-test high watermarks
 * Tracks the highest repetition and adaptive proportion counts since clear
 */

`timescale 1ns/100ps

module ht_watermark (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            active_i,
  input  logic [ent_ht_pkg::RegWidth-1:0] repcnt_cnt_i,
  input  logic [ent_ht_pkg::RegWidth-1:0] adaptp_cnt_i,
  output logic [ent_ht_pkg::RegWidth-1:0] repcnt_hiwater_o,
  output logic [ent_ht_pkg::RegWidth-1:0] adaptp_hiwater_o
);

  logic                            restart;
  logic [ent_ht_pkg::RegWidth-1:0] rep_hw_q, rep_hw_d;
  logic [ent_ht_pkg::RegWidth-1:0] ap_hw_q, ap_hw_d;

  // Next watermark, larger of current mark and count
  function automatic logic [ent_ht_pkg::RegWidth-1:0] hw_next(
    input logic                            clr,
    input logic [ent_ht_pkg::RegWidth-1:0] mark,
    input logic [ent_ht_pkg::RegWidth-1:0] cnt
  );
    logic [ent_ht_pkg::RegWidth-1:0] res;
    res = mark;
    if (clr) begin
      res = '0;
    end else if (cnt > mark) begin
      res = cnt;
    end
    return res;
  endfunction

  assign restart = !active_i || clear_i;

  assign rep_hw_d = hw_next(restart, rep_hw_q, repcnt_cnt_i);
  assign ap_hw_d  = hw_next(restart, ap_hw_q, adaptp_cnt_i);

  // Marks lag the counts by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rep_hw_q <= '0;
      ap_hw_q  <= '0;
    end else begin
      rep_hw_q <= rep_hw_d;
      ap_hw_q  <= ap_hw_d;
    end
  end

  assign repcnt_hiwater_o = rep_hw_q;
  assign adaptp_hiwater_o = ap_hw_q;

endmodule : ht_watermark

// ==== source/ht_alert_ctrl.sv ====
/*
 * Health-test alert controller
 * Counts failure pulses and holds a level alert once the limit is reached
 */

`timescale 1ns/100ps

module ht_alert_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            active_i,
  input  logic                            repcnt_fail_i,
  input  logic                            adaptp_fail_i,
  input  logic [ent_ht_pkg::RegWidth-1:0] alert_thresh_i,
  output logic [ent_ht_pkg::RegWidth-1:0] fail_total_o,
  output ent_ht_pkg::alert_state_e        alert_state_o,
  output logic                            alert_o
);

  logic                            restart;
  logic                            any_fail;
  logic                            limit_hit;
  logic [ent_ht_pkg::RegWidth-1:0] fail_total_q, fail_total_d;
  ent_ht_pkg::alert_state_e        state_q, state_d;

  assign restart = !active_i || clear_i;

  // Both tests failing in one cycle still count once
  assign any_fail = repcnt_fail_i || adaptp_fail_i;

  // Saturating failure total
  always_comb begin
    fail_total_d = fail_total_q;
    if (restart) begin
      fail_total_d = '0;
    end else if (any_fail && !(&fail_total_q)) begin
      fail_total_d = fail_total_q + 1'b1;
    end
  end

  // Zero limit never alerts
  assign limit_hit = (alert_thresh_i != '0) && (fail_total_q >= alert_thresh_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ent_ht_pkg::AlIdle: begin
        if (!restart) begin
          state_d = ent_ht_pkg::AlRun;
        end
      end
      ent_ht_pkg::AlRun: begin
        if (restart) begin
          state_d = ent_ht_pkg::AlIdle;
        end else if (limit_hit) begin
          state_d = ent_ht_pkg::AlAlert;
        end
      end
      ent_ht_pkg::AlAlert: begin
        // Held until cleared or disabled
        if (restart) begin
          state_d = ent_ht_pkg::AlIdle;
        end
      end
      default: state_d = ent_ht_pkg::AlIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fail_total_q <= '0;
      state_q      <= ent_ht_pkg::AlIdle;
    end else begin
      fail_total_q <= fail_total_d;
      state_q      <= state_d;
    end
  end

  assign fail_total_o  = fail_total_q;
  assign alert_state_o = state_q;
  assign alert_o       = (state_q == ent_ht_pkg::AlAlert);

endmodule : ht_alert_ctrl

// ==== source/ent_ht_top.sv ====
/*
 * Entropy source health-test subsystem
 * Repetition count and adaptive proportion tests with watermarks and alert
 */

`timescale 1ns/100ps

module ent_ht_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [ent_ht_pkg::RngBusWidth-1:0] entropy_bit_i,
  input  logic                               entropy_bit_vld_i,
  input  logic                               active_i,
  input  logic                               clear_i,
  input  logic [ent_ht_pkg::RegWidth-1:0]    repcnt_thresh_i,
  input  logic [ent_ht_pkg::RegWidth-1:0]    adaptp_thresh_i,
  input  logic [ent_ht_pkg::RegWidth-1:0]    alert_thresh_i,
  output logic [ent_ht_pkg::RegWidth-1:0]    repcnt_cnt_o,
  output logic [ent_ht_pkg::RegWidth-1:0]    adaptp_cnt_o,
  output logic [ent_ht_pkg::RegWidth-1:0]    repcnt_hiwater_o,
  output logic [ent_ht_pkg::RegWidth-1:0]    adaptp_hiwater_o,
  output logic                               repcnt_fail_o,
  output logic                               adaptp_fail_o,
  output logic [ent_ht_pkg::RegWidth-1:0]    fail_total_o,
  output ent_ht_pkg::alert_state_e           alert_state_o,
  output logic                               alert_o,
  output logic                               count_err_o
);

  logic repcnt_err;
  logic adaptp_err;

  // Stuck symbol test
  repcnt_ht u_repcnt (
    .clk_i,
    .rst_ni,
    .entropy_bit_i,
    .entropy_bit_vld_i,
    .clear_i,
    .active_i,
    .thresh_i          (repcnt_thresh_i),
    .test_cnt_o        (repcnt_cnt_o),
    .test_fail_pulse_o (repcnt_fail_o),
    .count_err_o       (repcnt_err)
  );

  // Symbol bias test
  adaptp_ht u_adaptp (
    .clk_i,
    .rst_ni,
    .entropy_bit_i,
    .entropy_bit_vld_i,
    .clear_i,
    .active_i,
    .thresh_i          (adaptp_thresh_i),
    .test_cnt_o        (adaptp_cnt_o),
    .test_fail_pulse_o (adaptp_fail_o),
    .count_err_o       (adaptp_err)
  );

  ht_watermark u_watermark (
    .clk_i,
    .rst_ni,
    .clear_i,
    .active_i,
    .repcnt_cnt_i     (repcnt_cnt_o),
    .adaptp_cnt_i     (adaptp_cnt_o),
    .repcnt_hiwater_o,
    .adaptp_hiwater_o
  );

  ht_alert_ctrl u_alert_ctrl (
    .clk_i,
    .rst_ni,
    .clear_i,
    .active_i,
    .repcnt_fail_i  (repcnt_fail_o),
    .adaptp_fail_i  (adaptp_fail_o),
    .alert_thresh_i,
    .fail_total_o,
    .alert_state_o,
    .alert_o
  );

  // Either hardened counter out of step
  assign count_err_o = repcnt_err || adaptp_err;

endmodule : ent_ht_top

// ==== tests/tb_ent_ht.sv ====
/*
 * Testbench for the entropy health-test subsystem
 * Directed tests with a cycle-level reference model checked every cycle
 */

`timescale 1ns/100ps

module tb_ent_ht;

  // Summed test lengths plus margin
  localparam int MaxCycles = 250 + 250;

  logic                               clk_i;
  logic                               rst_ni;
  logic [ent_ht_pkg::RngBusWidth-1:0] entropy_bit_i;
  logic                               entropy_bit_vld_i;
  logic                               active_i;
  logic                               clear_i;
  logic [ent_ht_pkg::RegWidth-1:0]    repcnt_thresh_i;
  logic [ent_ht_pkg::RegWidth-1:0]    adaptp_thresh_i;
  logic [ent_ht_pkg::RegWidth-1:0]    alert_thresh_i;
  logic [ent_ht_pkg::RegWidth-1:0]    repcnt_cnt_o;
  logic [ent_ht_pkg::RegWidth-1:0]    adaptp_cnt_o;
  logic [ent_ht_pkg::RegWidth-1:0]    repcnt_hiwater_o;
  logic [ent_ht_pkg::RegWidth-1:0]    adaptp_hiwater_o;
  logic                               repcnt_fail_o;
  logic                               adaptp_fail_o;
  logic [ent_ht_pkg::RegWidth-1:0]    fail_total_o;
  ent_ht_pkg::alert_state_e           alert_state_o;
  logic                               alert_o;
  logic                               count_err_o;

  // Error counts and current test
  int    value_errs;
  int    other_errs;
  int    cycles;
  string test_name;

  // Pulse bookkeeping
  int seen_rep;
  int seen_ap;
  int exp_rep;
  int exp_ap;

  // Reference model state
  logic [ent_ht_pkg::RegWidth-1:0]    m_rep_cnt;
  logic [ent_ht_pkg::RegWidth-1:0]    m_ap_cnt;
  logic [ent_ht_pkg::RegWidth-1:0]    m_rep_hw;
  logic [ent_ht_pkg::RegWidth-1:0]    m_ap_hw;
  logic [ent_ht_pkg::RegWidth-1:0]    m_total;
  logic [ent_ht_pkg::RngBusWidth-1:0] m_prev;
  logic [ent_ht_pkg::RngBusWidth-1:0] m_ref;
  int                                 m_idx;
  logic                               m_upd;
  logic                               m_end;
  ent_ht_pkg::alert_state_e           m_state;
  logic                               m_restart;
  logic                               m_rep_fail;
  logic                               m_ap_fail;
  logic                               m_limit;

  ent_ht_top dut0 (
    .clk_i,
    .rst_ni,
    .entropy_bit_i,
    .entropy_bit_vld_i,
    .active_i,
    .clear_i,
    .repcnt_thresh_i,
    .adaptp_thresh_i,
    .alert_thresh_i,
    .repcnt_cnt_o,
    .adaptp_cnt_o,
    .repcnt_hiwater_o,
    .adaptp_hiwater_o,
    .repcnt_fail_o,
    .adaptp_fail_o,
    .fail_total_o,
    .alert_state_o,
    .alert_o,
    .count_err_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > MaxCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_count(input string what, input logic [ent_ht_pkg::RegWidth-1:0] exp,
                             input logic [ent_ht_pkg::RegWidth-1:0] act);
    if (exp !== act) begin
      value_errs++;
      $display("error %s %s: expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      value_errs++;
      $display("error %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_state(input string what, input ent_ht_pkg::alert_state_e exp,
                             input ent_ht_pkg::alert_state_e act);
    if (exp !== act) begin
      value_errs++;
      $display("error %s %s: expected %s actual %s", test_name, what, exp.name(), act.name());
    end
  endtask

  // Compare on the falling edge, then predict the next rising edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      m_rep_cnt = '0;
      m_ap_cnt  = '0;
      m_rep_hw  = '0;
      m_ap_hw   = '0;
      m_total   = '0;
      m_prev    = '0;
      m_ref     = '0;
      m_idx     = 0;
      m_upd     = 1'b0;
      m_end     = 1'b0;
      m_state   = ent_ht_pkg::AlIdle;
    end else begin
      m_restart  = !active_i || clear_i;
      m_rep_fail = active_i && m_upd && (m_rep_cnt >= repcnt_thresh_i);
      m_ap_fail  = active_i && m_end && (m_ap_cnt >= adaptp_thresh_i);
      check_count("repcnt count", m_rep_cnt, repcnt_cnt_o);
      check_count("adaptp count", m_ap_cnt, adaptp_cnt_o);
      check_count("repcnt watermark", m_rep_hw, repcnt_hiwater_o);
      check_count("adaptp watermark", m_ap_hw, adaptp_hiwater_o);
      check_count("fail total", m_total, fail_total_o);
      check_bit("repcnt fail", m_rep_fail, repcnt_fail_o);
      check_bit("adaptp fail", m_ap_fail, adaptp_fail_o);
      check_bit("alert", m_state == ent_ht_pkg::AlAlert, alert_o);
      check_bit("count error", 1'b0, count_err_o);
      check_state("alert state", m_state, alert_state_o);
      exp_rep += int'(m_rep_fail);
      exp_ap  += int'(m_ap_fail);
      seen_rep += int'(repcnt_fail_o === 1'b1);
      seen_ap  += int'(adaptp_fail_o === 1'b1);
      // Watermarks and alert use the values before this edge
      if (m_restart) begin
        m_rep_hw = '0;
        m_ap_hw  = '0;
      end else begin
        if (m_rep_cnt > m_rep_hw) m_rep_hw = m_rep_cnt;
        if (m_ap_cnt > m_ap_hw) m_ap_hw = m_ap_cnt;
      end
      m_limit = (alert_thresh_i != '0) && (m_total >= alert_thresh_i);
      case (m_state)
        ent_ht_pkg::AlIdle:  if (!m_restart) m_state = ent_ht_pkg::AlRun;
        ent_ht_pkg::AlRun: begin
          if (m_restart) m_state = ent_ht_pkg::AlIdle;
          else if (m_limit) m_state = ent_ht_pkg::AlAlert;
        end
        default: if (m_restart) m_state = ent_ht_pkg::AlIdle;
      endcase
      if (m_restart) begin
        m_total = '0;
      end else if ((m_rep_fail || m_ap_fail) && m_total != '1) begin
        m_total = m_total + 1'b1;
      end
      // Repetition count
      m_upd = entropy_bit_vld_i;
      if (m_restart) begin
        m_rep_cnt = ent_ht_pkg::RegWidth'(1);
        m_prev    = '0;
      end else if (entropy_bit_vld_i) begin
        if (entropy_bit_i == m_prev) begin
          if (m_rep_cnt != '1) m_rep_cnt = m_rep_cnt + 1'b1;
        end else begin
          m_rep_cnt = ent_ht_pkg::RegWidth'(1);
        end
        m_prev = entropy_bit_i;
      end
      // Adaptive proportion window
      m_end = 1'b0;
      if (m_restart) begin
        m_idx    = 0;
        m_ap_cnt = '0;
      end else if (entropy_bit_vld_i) begin
        if (m_idx == 0) begin
          m_ref    = entropy_bit_i;
          m_ap_cnt = ent_ht_pkg::RegWidth'(1);
        end else if (entropy_bit_i == m_ref && m_ap_cnt != '1) begin
          m_ap_cnt = m_ap_cnt + 1'b1;
        end
        m_end = (m_idx == ent_ht_pkg::ApWindow - 1);
        m_idx = m_end ? 0 : m_idx + 1;
      end
    end
  end

  task automatic drive(input logic vld, input logic [ent_ht_pkg::RngBusWidth-1:0] sym);
    @(posedge clk_i);
    entropy_bit_vld_i <= vld;
    entropy_bit_i     <= sym;
  endtask

  task automatic send_run(input logic [ent_ht_pkg::RngBusWidth-1:0] sym, input int n);
    repeat (n) drive(1'b1, sym);
  endtask

  // Idle input and let pulses and watermarks catch up
  task automatic settle();
    drive(1'b0, '0);
    repeat (4) @(negedge clk_i);
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
  endtask

  task automatic test_reset();
    test_name = "reset";
    repeat (2) @(negedge clk_i);
    check_count("repcnt count", ent_ht_pkg::RegWidth'(1), repcnt_cnt_o);
    check_count("adaptp count", '0, adaptp_cnt_o);
    check_count("fail total", '0, fail_total_o);
    check_bit("alert", 1'b0, alert_o);
    check_state("alert state", ent_ht_pkg::AlIdle, alert_state_o);
  endtask

  task automatic test_repcnt();
    int base;
    test_name = "repcnt";
    @(posedge clk_i);
    repcnt_thresh_i <= ent_ht_pkg::RegWidth'(5);
    adaptp_thresh_i <= ent_ht_pkg::RegWidth'(16);
    active_i        <= 1'b1;
    base = seen_rep;
    // Leading zeros count from 2 and reach threshold once
    send_run(4'd0, 4);
    send_run(4'd5, 6);
    settle();
    check_count("run length", ent_ht_pkg::RegWidth'(6), repcnt_cnt_o);
    send_run(4'd9, 2);
    send_run(4'd3, 7);
    settle();
    check_count("pulses", ent_ht_pkg::RegWidth'(6), ent_ht_pkg::RegWidth'(seen_rep - base));
  endtask

  task automatic test_adaptp();
    int base;
    test_name = "adaptp";
    @(posedge clk_i);
    repcnt_thresh_i <= ent_ht_pkg::RegWidth'(100);
    adaptp_thresh_i <= ent_ht_pkg::RegWidth'(8);
    pulse_clear();
    base = seen_ap;
    send_run(4'd7, 16);
    settle();
    check_count("window count", ent_ht_pkg::RegWidth'(16), adaptp_cnt_o);
    check_count("full window pulses", ent_ht_pkg::RegWidth'(1),
                ent_ht_pkg::RegWidth'(seen_ap - base));
    // Exactly threshold matches, then one short of it
    for (int w = 0; w < 2; w++) begin
      base = seen_ap;
      send_run(4'd2, 8 - w);
      for (int i = 0; i < 8 + w; i++) begin
        drive(1'b1, ent_ht_pkg::RngBusWidth'(3 + (i % 4)));
        if (i % 5 == 4) drive(1'b0, '0);
      end
      settle();
      check_count("threshold window pulses", ent_ht_pkg::RegWidth'(1 - w),
                  ent_ht_pkg::RegWidth'(seen_ap - base));
    end
    // Random windows with gaps
    for (int w = 0; w < 4; w++) begin
      for (int i = 0; i < ent_ht_pkg::ApWindow; i++) begin
        drive(1'b1, ent_ht_pkg::RngBusWidth'($urandom() % 4));
        if (i % 3 == 2) drive(1'b0, '0);
      end
    end
    settle();
  endtask

  task automatic test_watermark();
    test_name = "watermark";
    pulse_clear();
    send_run(4'd0, 5);
    drive(1'b1, 4'd1);
    settle();
    check_count("repcnt watermark", ent_ht_pkg::RegWidth'(6), repcnt_hiwater_o);
    check_count("adaptp watermark", ent_ht_pkg::RegWidth'(5), adaptp_hiwater_o);
    pulse_clear();
    settle();
    // Count rests at 1 after clear
    check_count("repcnt watermark", ent_ht_pkg::RegWidth'(1), repcnt_hiwater_o);
    check_count("adaptp watermark", '0, adaptp_hiwater_o);
  endtask

  task automatic test_alert();
    test_name = "alert";
    @(posedge clk_i);
    alert_thresh_i  <= ent_ht_pkg::RegWidth'(3);
    repcnt_thresh_i <= ent_ht_pkg::RegWidth'(2);
    adaptp_thresh_i <= ent_ht_pkg::RegWidth'(16);
    pulse_clear();
    send_run(4'd4, 4);
    settle();
    check_count("fail total", ent_ht_pkg::RegWidth'(3), fail_total_o);
    check_state("alert state", ent_ht_pkg::AlAlert, alert_state_o);
    check_bit("alert", 1'b1, alert_o);
    @(posedge clk_i);
    active_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    active_i <= 1'b1;
    @(negedge clk_i);
    check_state("alert state", ent_ht_pkg::AlIdle, alert_state_o);
    check_count("fail total", '0, fail_total_o);
    check_bit("alert", 1'b0, alert_o);
    settle();
    check_state("alert state", ent_ht_pkg::AlRun, alert_state_o);
  endtask

  initial begin
    void'($urandom(96));
    value_errs        = 0;
    other_errs        = 0;
    cycles            = 0;
    seen_rep          = 0;
    seen_ap           = 0;
    exp_rep           = 0;
    exp_ap            = 0;
    test_name         = "init";
    rst_ni            = 1'b0;
    entropy_bit_i     = '0;
    entropy_bit_vld_i = 1'b0;
    active_i          = 1'b0;
    clear_i           = 1'b0;
    repcnt_thresh_i   = '0;
    adaptp_thresh_i   = '0;
    alert_thresh_i    = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_repcnt();
    test_adaptp();
    test_watermark();
    test_alert();
    if (seen_rep != exp_rep || seen_ap != exp_ap) begin
      other_errs++;
      $display("fail pulse totals differ from the model: repcnt %0d of %0d, adaptp %0d of %0d",
               seen_rep, exp_rep, seen_ap, exp_ap);
    end
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_ent_ht

// ==== sources.f ====
source/ent_ht_pkg.sv
source/redun_count.sv
source/repcnt_ht.sv
source/adaptp_ht.sv
source/ht_watermark.sv
source/ht_alert_ctrl.sv
source/ent_ht_top.sv
tests/tb_ent_ht.sv

// ==== Makefile ====
# Verilator simulation of the health-test subsystem

TOP := tb_ent_ht

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: sim clean
